//--- common/fc_pkg.sv
`default_nettype none

package fc_pkg;

    // ********************
    // Core bus payloads
    // ********************

    // One request on a core or memory bus, qualified by a separate req line
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic        we;
    } tcdm_req_t;

    // Response data returned with rvalid
    typedef struct packed {
        logic [31:0] rdata;
    } tcdm_rsp_t;

    // ********************
    // Encodings
    // ********************

    // Target port of a core request
    typedef enum logic {
        REGION_L2  = 1'b0,
        REGION_SCM = 1'b1
    } fc_region_e;

    // Interrupt controller state
    typedef enum logic {
        IRQ_IDLE     = 1'b0,
        IRQ_WAIT_ACK = 1'b1
    } irq_state_e;

    // ********************
    // Address map
    // ********************

    // Private SCM bank, end addresses are exclusive
    localparam logic [31:0] SCM_START_ADDR       = 32'h1A00_0000;
    localparam logic [31:0] SCM_END_ADDR         = 32'h1A00_8000;

    // Alias of the SCM bank at the bottom of the map
    localparam logic [31:0] ALIAS_SCM_START_ADDR = 32'h0000_0000;
    localparam logic [31:0] ALIAS_SCM_END_ADDR   = 32'h0000_8000;

    // Interrupt line held while the event FIFO has entries
    localparam logic [4:0]  FIFO_EVENT_ID        = 5'd26;

endpackage

`default_nettype wire

//--- hw/fc_demux/fc_demux.sv
`timescale 1ns/1ps
`default_nettype none

module fc_demux import fc_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      reset_i,

    // Core side
    input  wire logic      core_req_i,
    input  wire tcdm_req_t core_req_data_i,
    output logic           core_gnt_o,
    output logic           core_rvalid_o,
    output tcdm_rsp_t      core_rsp_o,

    // L2 port
    output logic           l2_req_o,
    output tcdm_req_t      l2_req_data_o,
    input  wire logic      l2_gnt_i,
    input  wire logic      l2_rvalid_i,
    input  wire tcdm_rsp_t l2_rsp_i,

    // SCM port
    output logic           scm_req_o,
    output tcdm_req_t      scm_req_data_o,
    input  wire logic      scm_gnt_i,
    input  wire logic      scm_rvalid_i,
    input  wire tcdm_rsp_t scm_rsp_i
);

    fc_region_e req_region;
    fc_region_e rsp_region_q;

    // Unsigned range check, true for start <= addr < end
    function automatic logic in_window(
        input logic [31:0] addr,
        input logic [31:0] start_addr,
        input logic [31:0] end_addr
    );
        return (addr - start_addr) < (end_addr - start_addr);
    endfunction

    // ********************
    // Request path
    // ********************

    always_comb begin
        if (in_window(core_req_data_i.addr, SCM_START_ADDR, SCM_END_ADDR) ||
            in_window(core_req_data_i.addr, ALIAS_SCM_START_ADDR, ALIAS_SCM_END_ADDR)) begin
            req_region = REGION_SCM;
        end else begin
            req_region = REGION_L2;
        end
    end

    assign l2_req_o  = core_req_i && (req_region == REGION_L2);
    assign scm_req_o = core_req_i && (req_region == REGION_SCM);

    // Payload goes to both ports, only one of them sees req
    assign l2_req_data_o  = core_req_data_i;
    assign scm_req_data_o = core_req_data_i;

    // Grant comes back from the selected target unchanged
    assign core_gnt_o = (req_region == REGION_SCM) ? scm_gnt_i : l2_gnt_i;

    // ********************
    // Response path
    // ********************

    // Response follows its grant by one cycle, so one register is enough
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_region_q <= REGION_L2;
        end else if (core_req_i && core_gnt_o) begin
            rsp_region_q <= req_region;
        end
    end

    always_comb begin
        if (rsp_region_q == REGION_SCM) begin
            core_rvalid_o = scm_rvalid_i;
            core_rsp_o    = scm_rsp_i;
        end else begin
            core_rvalid_o = l2_rvalid_i;
            core_rsp_o    = l2_rsp_i;
        end
    end

endmodule

`default_nettype wire

//--- hw/fc_event_unit/fc_event_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fc_event_fifo #(
    parameter int EVENT_ID_WIDTH   = 8,
    parameter int EVENT_FIFO_DEPTH = 4
) (
    input  wire logic                      clk_i,
    input  wire logic                      reset_i,
    input  wire logic                      push_i,
    input  wire logic [EVENT_ID_WIDTH-1:0] push_data_i,
    output logic                           fulln_o,
    input  wire logic                      pop_i,
    output logic                           empty_o,
    output logic [EVENT_ID_WIDTH-1:0]      head_o
);

    localparam int PTR_W = (EVENT_FIFO_DEPTH > 1) ? $clog2(EVENT_FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(EVENT_FIFO_DEPTH + 1);

    logic [EVENT_ID_WIDTH-1:0] mem [EVENT_FIFO_DEPTH];
    logic [PTR_W-1:0]          wr_ptr_q;
    logic [PTR_W-1:0]          rd_ptr_q;
    logic [CNT_W-1:0]          count_q;
    logic                      do_push;
    logic                      do_pop;

    assign fulln_o = (count_q != CNT_W'(EVENT_FIFO_DEPTH));
    assign empty_o = (count_q == '0);
    assign head_o  = mem[rd_ptr_q];

    // Push while full and pop while empty are dropped
    assign do_push = push_i && fulln_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(EVENT_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(EVENT_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/fc_event_unit/fc_event_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fc_event_unit import fc_pkg::*; #(
    parameter int EVENT_ID_WIDTH   = 8,
    parameter int EVENT_FIFO_DEPTH = 4
) (
    input  wire logic                      clk_i,
    input  wire logic                      reset_i,

    input  wire logic [31:0]               events_i,
    input  wire logic                      event_fifo_valid_i,
    input  wire logic [EVENT_ID_WIDTH-1:0] event_fifo_data_i,
    output logic                           event_fifo_fulln_o,

    output logic                           core_irq_req_o,
    output logic [4:0]                     core_irq_id_o,
    input  wire logic                      core_irq_ack_i,
    input  wire logic [4:0]                core_irq_ack_id_i,

    output logic [EVENT_ID_WIDTH-1:0]      event_id_o
);

    irq_state_e  state_q;
    logic [31:0] pending_q;
    logic [31:0] pending_eff;
    logic [31:0] fifo_mask;
    logic [31:0] clr_mask;
    logic [4:0]  irq_id_q;
    logic        ack_fire;
    logic        fifo_pop;
    logic        fifo_empty;

    // Highest set bit wins
    function automatic logic [4:0] highest_pending(input logic [31:0] vec);
        logic [4:0] id;
        id = '0;
        for (int i = 0; i < 32; i++) begin
            if (vec[i]) begin
                id = 5'(i);
            end
        end
        return id;
    endfunction

    fc_event_fifo #(
        .EVENT_ID_WIDTH   ( EVENT_ID_WIDTH   ),
        .EVENT_FIFO_DEPTH ( EVENT_FIFO_DEPTH )
    ) fc_event_fifo_i (
        .clk_i       ( clk_i              ),
        .reset_i     ( reset_i            ),
        .push_i      ( event_fifo_valid_i ),
        .push_data_i ( event_fifo_data_i  ),
        .fulln_o     ( event_fifo_fulln_o ),
        .pop_i       ( fifo_pop           ),
        .empty_o     ( fifo_empty         ),
        .head_o      ( event_id_o         )
    );

    // ********************
    // Pending events
    // ********************

    assign ack_fire = (state_q == IRQ_WAIT_ACK) && core_irq_ack_i;
    assign fifo_pop = ack_fire && (core_irq_ack_id_i == FIFO_EVENT_ID);

    always_comb begin
        fifo_mask                = '0;
        fifo_mask[FIFO_EVENT_ID] = !fifo_empty;
        clr_mask                 = '0;
        clr_mask[core_irq_ack_id_i] = ack_fire;
    end

    // FIFO line stays asserted as long as entries remain
    assign pending_eff = pending_q | fifo_mask;

    // A new event on the acked line keeps its bit set
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q & ~clr_mask) | events_i;
        end
    end

    // ********************
    // Request FSM
    // ********************

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IRQ_IDLE;
        end else begin
            case (state_q)
                IRQ_IDLE:     if (|pending_eff) state_q <= IRQ_WAIT_ACK;
                IRQ_WAIT_ACK: if (core_irq_ack_i) state_q <= IRQ_IDLE;
                default:      state_q <= IRQ_IDLE;
            endcase
        end
    end

    // Id is only sampled when leaving idle, held until the ack
    always_ff @(posedge clk_i) begin
        if (state_q == IRQ_IDLE && |pending_eff) begin
            irq_id_q <= highest_pending(pending_eff);
        end
    end

    assign core_irq_req_o = (state_q == IRQ_WAIT_ACK);
    assign core_irq_id_o  = irq_id_q;

endmodule

`default_nettype wire

//--- hw/fc_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module fc_subsystem import fc_pkg::*; #(
    parameter int EVENT_ID_WIDTH   = 8,
    parameter int EVENT_FIFO_DEPTH = 4
) (
    input  wire logic                      clk_i,
    input  wire logic                      reset_i,

    // Core instruction bus
    input  wire logic                      instr_req_i,
    input  wire tcdm_req_t                 instr_req_data_i,
    output logic                           instr_gnt_o,
    output logic                           instr_rvalid_o,
    output tcdm_rsp_t                      instr_rsp_o,

    // Core data bus
    input  wire logic                      data_req_i,
    input  wire tcdm_req_t                 data_req_data_i,
    output logic                           data_gnt_o,
    output logic                           data_rvalid_o,
    output tcdm_rsp_t                      data_rsp_o,

    // Memory ports
    output logic                           l2_instr_req_o,
    output tcdm_req_t                      l2_instr_req_data_o,
    input  wire logic                      l2_instr_gnt_i,
    input  wire logic                      l2_instr_rvalid_i,
    input  wire tcdm_rsp_t                 l2_instr_rsp_i,

    output logic                           scm_instr_req_o,
    output tcdm_req_t                      scm_instr_req_data_o,
    input  wire logic                      scm_instr_gnt_i,
    input  wire logic                      scm_instr_rvalid_i,
    input  wire tcdm_rsp_t                 scm_instr_rsp_i,

    output logic                           l2_data_req_o,
    output tcdm_req_t                      l2_data_req_data_o,
    input  wire logic                      l2_data_gnt_i,
    input  wire logic                      l2_data_rvalid_i,
    input  wire tcdm_rsp_t                 l2_data_rsp_i,

    output logic                           scm_data_req_o,
    output tcdm_req_t                      scm_data_req_data_o,
    input  wire logic                      scm_data_gnt_i,
    input  wire logic                      scm_data_rvalid_i,
    input  wire tcdm_rsp_t                 scm_data_rsp_i,

    // Events and interrupts
    input  wire logic [31:0]               events_i,
    input  wire logic                      event_fifo_valid_i,
    input  wire logic [EVENT_ID_WIDTH-1:0] event_fifo_data_i,
    output logic                           event_fifo_fulln_o,
    output logic                           core_irq_req_o,
    output logic [4:0]                     core_irq_id_o,
    input  wire logic                      core_irq_ack_i,
    input  wire logic [4:0]                core_irq_ack_id_i,
    output logic [EVENT_ID_WIDTH-1:0]      event_id_o
);

    // ********************
    // Bus demultiplexers
    // ********************

    fc_demux fc_demux_instr_i (
        .clk_i           ( clk_i                ),
        .reset_i         ( reset_i              ),
        .core_req_i      ( instr_req_i          ),
        .core_req_data_i ( instr_req_data_i     ),
        .core_gnt_o      ( instr_gnt_o          ),
        .core_rvalid_o   ( instr_rvalid_o       ),
        .core_rsp_o      ( instr_rsp_o          ),
        .l2_req_o        ( l2_instr_req_o       ),
        .l2_req_data_o   ( l2_instr_req_data_o  ),
        .l2_gnt_i        ( l2_instr_gnt_i       ),
        .l2_rvalid_i     ( l2_instr_rvalid_i    ),
        .l2_rsp_i        ( l2_instr_rsp_i       ),
        .scm_req_o       ( scm_instr_req_o      ),
        .scm_req_data_o  ( scm_instr_req_data_o ),
        .scm_gnt_i       ( scm_instr_gnt_i      ),
        .scm_rvalid_i    ( scm_instr_rvalid_i   ),
        .scm_rsp_i       ( scm_instr_rsp_i      )
    );

    fc_demux fc_demux_data_i (
        .clk_i           ( clk_i               ),
        .reset_i         ( reset_i             ),
        .core_req_i      ( data_req_i          ),
        .core_req_data_i ( data_req_data_i     ),
        .core_gnt_o      ( data_gnt_o          ),
        .core_rvalid_o   ( data_rvalid_o       ),
        .core_rsp_o      ( data_rsp_o          ),
        .l2_req_o        ( l2_data_req_o       ),
        .l2_req_data_o   ( l2_data_req_data_o  ),
        .l2_gnt_i        ( l2_data_gnt_i       ),
        .l2_rvalid_i     ( l2_data_rvalid_i    ),
        .l2_rsp_i        ( l2_data_rsp_i       ),
        .scm_req_o       ( scm_data_req_o      ),
        .scm_req_data_o  ( scm_data_req_data_o ),
        .scm_gnt_i       ( scm_data_gnt_i      ),
        .scm_rvalid_i    ( scm_data_rvalid_i   ),
        .scm_rsp_i       ( scm_data_rsp_i      )
    );

    // ********************
    // Event unit
    // ********************

    fc_event_unit #(
        .EVENT_ID_WIDTH   ( EVENT_ID_WIDTH   ),
        .EVENT_FIFO_DEPTH ( EVENT_FIFO_DEPTH )
    ) fc_eu_i (
        .clk_i              ( clk_i              ),
        .reset_i            ( reset_i            ),
        .events_i           ( events_i           ),
        .event_fifo_valid_i ( event_fifo_valid_i ),
        .event_fifo_data_i  ( event_fifo_data_i  ),
        .event_fifo_fulln_o ( event_fifo_fulln_o ),
        .core_irq_req_o     ( core_irq_req_o     ),
        .core_irq_id_o      ( core_irq_id_o      ),
        .core_irq_ack_i     ( core_irq_ack_i     ),
        .core_irq_ack_id_i  ( core_irq_ack_id_i  ),
        .event_id_o         ( event_id_o         )
    );

endmodule

`default_nettype wire

//--- tb/fc_subsystem_properties.sv
`timescale 1ns/1ps
`default_nettype none

module fc_demux_properties (
    input wire logic clk_i,
    input wire logic reset_i,
    input wire logic core_req_i,
    input wire logic core_gnt_o,
    input wire logic core_rvalid_o,
    input wire logic l2_req_o,
    input wire logic scm_req_o
);

    // Only one target port may see a request
    one_port_only: assert property (
        @(posedge clk_i) disable iff (reset_i) !(l2_req_o && scm_req_o)
    ) else $error("l2 and scm requests high in the same cycle");

    // Response comes exactly one cycle after the grant
    rvalid_after_grant: assert property (
        @(posedge clk_i) disable iff (reset_i) (core_req_i && core_gnt_o) |=> core_rvalid_o
    ) else $error("granted request got no response in the next cycle");

    rvalid_needs_grant: assert property (
        @(posedge clk_i) disable iff (reset_i) core_rvalid_o |-> $past(core_req_i && core_gnt_o)
    ) else $error("response without a grant in the previous cycle");

    no_req_in_reset: assert property (
        @(posedge clk_i) reset_i |-> !(l2_req_o || scm_req_o)
    ) else $error("memory request raised during reset");

endmodule

bind fc_demux fc_demux_properties demux_props_i (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .core_req_i    ( core_req_i    ),
    .core_gnt_o    ( core_gnt_o    ),
    .core_rvalid_o ( core_rvalid_o ),
    .l2_req_o      ( l2_req_o      ),
    .scm_req_o     ( scm_req_o     )
);

`default_nettype wire

//--- tb/fc_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fc_subsystem_tb import fc_pkg::*; ();

    localparam int EVENT_ID_WIDTH   = 8;
    localparam int EVENT_FIFO_DEPTH = 4;
    localparam int REQS_PER_TEST    = 400;
    // About 4000 cycles of traffic over all tests, doubled
    localparam int CYCLE_LIMIT      = 8000;

    typedef struct packed {
        logic      is_write;
        tcdm_rsp_t rsp;
    } exp_t;

    logic      clk_i;
    logic      reset_i;
    // Index 0 is the instruction bus, 1 the data bus
    logic      core_req [2];
    tcdm_req_t core_data [2];
    logic      core_gnt [2];
    logic      core_rvalid [2];
    tcdm_rsp_t core_rsp [2];
    // Port index is bus * 2 + region
    logic      mreq [4];
    tcdm_req_t mdata [4];
    logic      mgnt [4];
    logic      mrvalid [4];
    tcdm_rsp_t mrsp [4];

    logic [31:0]               events_i;
    logic                      event_fifo_valid_i;
    logic [EVENT_ID_WIDTH-1:0] event_fifo_data_i;
    logic                      event_fifo_fulln_o;
    logic                      core_irq_req_o;
    logic [4:0]                core_irq_id_o;
    logic                      core_irq_ack_i;
    logic [4:0]                core_irq_ack_id_i;
    logic [EVENT_ID_WIDTH-1:0] event_id_o;

    integer seed;
    int     errors;
    int     cycles = 0;
    int     mode;
    int     test_id;
    int     loaded_id;
    int     bus_left [2];
    int     issued [2];
    int     granted [2];
    exp_t   exp_q [2][$];

    logic [31:0]               mem_model [logic [33:0]];
    logic [31:0]               ref_mem [logic [33:0]];
    logic [31:0]               pend_model;
    logic [EVENT_ID_WIDTH-1:0] fifo_model [$];

    fc_subsystem #(
        .EVENT_ID_WIDTH   ( EVENT_ID_WIDTH   ),
        .EVENT_FIFO_DEPTH ( EVENT_FIFO_DEPTH )
    ) UUT (
        .clk_i ( clk_i ), .reset_i ( reset_i ),
        .instr_req_i ( core_req[0] ), .instr_req_data_i ( core_data[0] ),
        .instr_gnt_o ( core_gnt[0] ), .instr_rvalid_o ( core_rvalid[0] ),
        .instr_rsp_o ( core_rsp[0] ),
        .data_req_i ( core_req[1] ), .data_req_data_i ( core_data[1] ),
        .data_gnt_o ( core_gnt[1] ), .data_rvalid_o ( core_rvalid[1] ),
        .data_rsp_o ( core_rsp[1] ),
        .l2_instr_req_o ( mreq[0] ), .l2_instr_req_data_o ( mdata[0] ),
        .l2_instr_gnt_i ( mgnt[0] ), .l2_instr_rvalid_i ( mrvalid[0] ),
        .l2_instr_rsp_i ( mrsp[0] ),
        .scm_instr_req_o ( mreq[1] ), .scm_instr_req_data_o ( mdata[1] ),
        .scm_instr_gnt_i ( mgnt[1] ), .scm_instr_rvalid_i ( mrvalid[1] ),
        .scm_instr_rsp_i ( mrsp[1] ),
        .l2_data_req_o ( mreq[2] ), .l2_data_req_data_o ( mdata[2] ),
        .l2_data_gnt_i ( mgnt[2] ), .l2_data_rvalid_i ( mrvalid[2] ),
        .l2_data_rsp_i ( mrsp[2] ),
        .scm_data_req_o ( mreq[3] ), .scm_data_req_data_o ( mdata[3] ),
        .scm_data_gnt_i ( mgnt[3] ), .scm_data_rvalid_i ( mrvalid[3] ),
        .scm_data_rsp_i ( mrsp[3] ),
        .events_i ( events_i ), .event_fifo_valid_i ( event_fifo_valid_i ),
        .event_fifo_data_i ( event_fifo_data_i ), .event_fifo_fulln_o ( event_fifo_fulln_o ),
        .core_irq_req_o ( core_irq_req_o ), .core_irq_id_o ( core_irq_id_o ),
        .core_irq_ack_i ( core_irq_ack_i ), .core_irq_ack_id_i ( core_irq_ack_id_i ),
        .event_id_o ( event_id_o )
    );

    // ********************
    // Reference models
    // ********************

    function automatic logic [31:0] rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r;
    endfunction

    // Unwritten locations read back a pattern of port and address
    function automatic logic [31:0] fill_word(input logic [33:0] key);
        return {key[15:0], key[31:16]} ^ {key[33:32], 30'h1B3C_5A7D};
    endfunction

    function automatic fc_region_e expected_region(input logic [31:0] addr);
        if (addr >= SCM_START_ADDR && addr < SCM_END_ADDR) begin
            return REGION_SCM;
        end
        if (addr >= ALIAS_SCM_START_ADDR && addr < ALIAS_SCM_END_ADDR) begin
            return REGION_SCM;
        end
        return REGION_L2;
    endfunction

    function automatic logic [31:0] merge_be(input logic [31:0] old, input logic [31:0] wdata,
                                             input logic [3:0] be);
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                old[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return old;
    endfunction

    // Small offsets so that reads hit earlier writes
    function automatic logic [31:0] pick_addr(input int test_mode);
        logic [31:0] r;
        logic [31:0] off;
        r   = rand_word();
        off = {26'd0, r[5:2], 2'b00};
        if (test_mode == 1 && r[10]) begin
            case (r[13:11])
                3'd0:    return SCM_START_ADDR;
                3'd1:    return SCM_END_ADDR - 32'd4;
                3'd2:    return SCM_END_ADDR;
                3'd3:    return SCM_START_ADDR - 32'd4;
                3'd4:    return ALIAS_SCM_START_ADDR;
                3'd5:    return ALIAS_SCM_END_ADDR - 32'd4;
                3'd6:    return ALIAS_SCM_END_ADDR;
                default: return 32'hFFFF_FFFC;
            endcase
        end
        case (r[9:8])
            2'd0:    return SCM_START_ADDR + off;
            2'd1:    return ALIAS_SCM_START_ADDR + off;
            default: return 32'h1C00_0000 + off;
        endcase
    endfunction

    function automatic tcdm_req_t rand_req(input int b);
        tcdm_req_t   r;
        logic [31:0] w;
        w       = rand_word();
        r.addr  = pick_addr(mode);
        r.wdata = rand_word();
        r.we    = (b == 1) && w[0];
        r.be    = r.we ? w[7:4] : 4'hF;
        return r;
    endfunction

    function automatic logic [4:0] top_pending(input logic [31:0] vec);
        for (int i = 31; i >= 0; i--) begin
            if (vec[i]) begin
                return 5'(i);
            end
        end
        return 5'd0;
    endfunction

    // ********************
    // Compare tasks
    // ********************

    task automatic check_req(input tcdm_req_t got, input tcdm_req_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_rsp(input tcdm_rsp_t got, input tcdm_rsp_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_irq(input logic [4:0] got, input logic [4:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_event_id(input logic [EVENT_ID_WIDTH-1:0] got,
                                  input logic [EVENT_ID_WIDTH-1:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // ********************
    // Clock and bus agents
    // ********************

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    // Memories and core requester, one process so all sampling sees the same edge
    always @(posedge clk_i) begin
        logic [33:0] key;
        logic [31:0] r;
        logic [31:0] old;
        exp_t        e;
        fc_region_e  rgn;
        int          p;
        if (reset_i) begin
            for (int i = 0; i < 4; i++) begin
                mgnt[i]    <= 1'b0;
                mrvalid[i] <= 1'b0;
            end
            for (int b = 0; b < 2; b++) begin
                core_req[b] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                r       = rand_word();
                mgnt[i] <= (mode == 3) ? r[0] : (r[1:0] != 2'b00);
                if (mreq[i] && mgnt[i]) begin
                    key = {2'(i), mdata[i].addr};
                    old = mem_model.exists(key) ? mem_model[key] : fill_word(key);
                    if (mdata[i].we) begin
                        mem_model[key] = merge_be(old, mdata[i].wdata, mdata[i].be);
                        mrsp[i] <= r;
                    end else begin
                        mrsp[i] <= old;
                    end
                    mrvalid[i] <= 1'b1;
                end else begin
                    mrvalid[i] <= 1'b0;
                end
            end
            if (loaded_id != test_id) begin
                loaded_id  = test_id;
                bus_left[0] = REQS_PER_TEST;
                bus_left[1] = REQS_PER_TEST;
            end
            for (int b = 0; b < 2; b++) begin
                if (core_rvalid[b]) begin
                    if (exp_q[b].size() == 0) begin
                        report_error("response arrived with no request outstanding");
                    end else begin
                        e = exp_q[b].pop_front();
                        if (!e.is_write) begin
                            check_rsp(core_rsp[b], e.rsp, "read data");
                        end
                    end
                end
                if (core_req[b]) begin
                    rgn = expected_region(core_data[b].addr);
                    p   = b * 2 + int'(rgn);
                    check_flag(core_gnt[b], mgnt[p], "grant from predicted port");
                end
                if (core_req[b] && core_gnt[b]) begin
                    granted[b]++;
                    check_flag(mreq[p], 1'b1, "req on predicted port");
                    check_flag(mreq[p ^ 1], 1'b0, "req on other port");
                    check_req(mdata[p], core_data[b], "forwarded request");
                    key = {2'(p), core_data[b].addr};
                    old = ref_mem.exists(key) ? ref_mem[key] : fill_word(key);
                    e.is_write  = core_data[b].we;
                    e.rsp.rdata = old;
                    if (core_data[b].we) begin
                        ref_mem[key] = merge_be(old, core_data[b].wdata, core_data[b].be);
                    end
                    exp_q[b].push_back(e);
                end
                r = rand_word();
                if (!core_req[b] || core_gnt[b]) begin
                    if (bus_left[b] > 0 && (mode == 3 || r[1:0] != 2'b00)) begin
                        core_req[b]  <= 1'b1;
                        core_data[b] <= rand_req(b);
                        bus_left[b]--;
                        issued[b]++;
                    end else begin
                        core_req[b] <= 1'b0;
                    end
                end
            end
        end
    end

    // ********************
    // Tests
    // ********************

    task automatic finish_test(input string name, input int start_errors);
        if (issued[0] != granted[0] || issued[1] != granted[1]) begin
            report_error("a request was not granted exactly once");
        end
        $display("Test %s: %s", name, (errors == start_errors) ? "ok" : "FAILED");
    endtask

    task automatic run_bus_test(input int m, input string name);
        int start_errors;
        start_errors = errors;
        @(posedge clk_i);
        mode    <= m;
        test_id <= test_id + 1;
        repeat (3) @(negedge clk_i);
        while (bus_left[0] != 0 || bus_left[1] != 0 || core_req[0] || core_req[1] ||
               exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            @(negedge clk_i);
        end
        finish_test(name, start_errors);
    endtask

    task automatic serve_irqs();
        logic [31:0] live;
        logic [4:0]  got;
        while (pend_model != 0 || fifo_model.size() != 0) begin
            @(negedge clk_i);
            while (!core_irq_req_o) begin
                @(negedge clk_i);
            end
            live = pend_model;
            if (fifo_model.size() != 0) begin
                live[FIFO_EVENT_ID] = 1'b1;
            end
            got = core_irq_id_o;
            check_irq(got, top_pending(live), "interrupt id");
            if (got == FIFO_EVENT_ID && fifo_model.size() != 0) begin
                check_event_id(event_id_o, fifo_model[0], "event id at FIFO head");
                void'(fifo_model.pop_front());
            end
            pend_model[got] = 1'b0;
            @(posedge clk_i);
            core_irq_ack_i    <= 1'b1;
            core_irq_ack_id_i <= got;
            @(posedge clk_i);
            core_irq_ack_i    <= 1'b0;
        end
        repeat (6) begin
            @(negedge clk_i);
            if (core_irq_req_o) begin
                report_error("interrupt requested again without a new event");
            end
        end
    endtask

    task automatic irq_test();
        int          start_errors;
        logic [31:0] mask;
        start_errors = errors;
        repeat (6) begin
            mask = rand_word() & rand_word() & ~(32'h1 << FIFO_EVENT_ID);
            if (mask == 0) begin
                mask = 32'h1;
            end
            @(posedge clk_i);
            events_i   <= mask;
            pend_model = pend_model | mask;
            @(posedge clk_i);
            events_i   <= '0;
            serve_irqs();
        end
        finish_test("interrupt priority and acknowledge", start_errors);
    endtask

    task automatic fifo_test();
        int          start_errors;
        logic [31:0] w;
        start_errors = errors;
        for (int i = 0; i < EVENT_FIFO_DEPTH + 2; i++) begin
            w = rand_word();
            @(posedge clk_i);
            event_fifo_valid_i <= 1'b1;
            event_fifo_data_i  <= w[EVENT_ID_WIDTH-1:0];
            // The id driven above is taken on the next edge only if fulln is still high
            @(negedge clk_i);
            check_flag(event_fifo_fulln_o, fifo_model.size() < EVENT_FIFO_DEPTH, "fifo fulln");
            if (fifo_model.size() < EVENT_FIFO_DEPTH) begin
                fifo_model.push_back(w[EVENT_ID_WIDTH-1:0]);
            end
        end
        @(posedge clk_i);
        event_fifo_valid_i <= 1'b0;
        serve_irqs();
        @(negedge clk_i);
        check_flag(event_fifo_fulln_o, 1'b1, "fifo fulln after drain");
        finish_test("event FIFO", start_errors);
    endtask

    initial begin
        seed       = 23767;
        errors     = 0;
        mode       = 0;
        test_id    = 0;
        loaded_id  = 0;
        pend_model = '0;
        reset_i            = 1'b1;
        events_i           = '0;
        event_fifo_valid_i = 1'b0;
        event_fifo_data_i  = '0;
        core_irq_ack_i     = 1'b0;
        core_irq_ack_id_i  = '0;
        for (int i = 0; i < 2; i++) begin
            core_req[i]  = 1'b0;
            core_data[i] = '0;
            bus_left[i]  = 0;
            issued[i]    = 0;
            granted[i]   = 0;
        end
        for (int i = 0; i < 4; i++) begin
            mgnt[i]    = 1'b0;
            mrvalid[i] = 1'b0;
            mrsp[i]    = '0;
        end
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        check_flag(event_fifo_fulln_o, 1'b1, "fulln after reset");
        check_flag(core_irq_req_o, 1'b0, "irq request after reset");
        run_bus_test(1, "region routing");
        run_bus_test(2, "data integrity");
        run_bus_test(3, "back-pressure and overlap");
        irq_test();
        fifo_test();
        $display("Done: 5 tests, %0d errors, %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fc_subsystem.f
common/fc_pkg.sv
hw/fc_demux/fc_demux.sv
hw/fc_event_unit/fc_event_fifo.sv
hw/fc_event_unit/fc_event_unit.sv
hw/fc_subsystem.sv
tb/fc_subsystem_properties.sv
tb/fc_subsystem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the fc_subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f fc_subsystem.f \
    --top-module fc_subsystem_tb \
    -o fc_subsystem_sim \
    || { echo "Build failed"; exit 1; }

output="$(./obj_dir/fc_subsystem_sim 2>&1)"
echo "$output"

echo "$output" | grep -q "Regression passed" && exit 0 || exit 1
